//--- common/ibex_shell_cfg.svh
/*
 * Register file sizing macros for the core shell
 * Register count, address, data, check and codeword widths
 */

`ifndef IBEX_SHELL_CFG_SVH
`define IBEX_SHELL_CFG_SVH

// Architectural registers, entry zero included
`define RF_NUM_REGS 32

// Register index width
`define RF_ADDR_W 5

// Data word width
`define RF_DATA_W 32

// Hsiao SEC-DED check bits
`define RF_ECC_W 7

// Stored codeword, check field above data field
`define RF_CW_W (`RF_DATA_W + `RF_ECC_W)

`endif

//--- common/ibex_shell_pkg.sv
/*
 * Shared types for the core shell register file
 * Codeword, write and read port structs, Hsiao (39,32) table and functions
 */

`include "ibex_shell_cfg.svh"

package ibex_shell_pkg;

  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [`RF_DATA_W-1:0] rf_data_t;

  typedef struct packed {
    logic [`RF_ECC_W-1:0] check;
    rf_data_t             data;
  } rf_cw_t;

  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    rf_cw_t   wdata;
  } rf_wr_t;

  typedef struct packed {
    rf_data_t data;
    logic     err_single;
    logic     err_double;
  } rf_rd_t;

  //////////////////////////////
  // Hsiao (39,32) matrix
  //////////////////////////////

  // Columns by codeword bit, data bits are weight-3, check bits are unit vectors
  localparam logic [`RF_ECC_W-1:0] RF_ECC_COLS [`RF_CW_W] = '{
    7'h07, 7'h0B, 7'h13, 7'h23, 7'h43, 7'h0D, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0E,
    7'h16, 7'h26, 7'h46, 7'h1A, 7'h2A, 7'h4A, 7'h32, 7'h52,
    7'h62, 7'h1C, 7'h2C, 7'h4C, 7'h34, 7'h54, 7'h64, 7'h38,
    7'h01, 7'h02, 7'h04, 7'h08, 7'h10, 7'h20, 7'h40
  };

  // Check bits for a data word
  function automatic logic [`RF_ECC_W-1:0] rf_ecc_encode(rf_data_t data);
    logic [`RF_ECC_W-1:0] chk;
    chk = '0;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      if (data[i]) begin
        chk ^= RF_ECC_COLS[i];
      end
    end
    return chk;
  endfunction

  // Zero for a clean codeword, otherwise the xor of the flipped columns
  function automatic logic [`RF_ECC_W-1:0] rf_ecc_syndrome(rf_cw_t cw);
    logic [`RF_CW_W-1:0]  bits;
    logic [`RF_ECC_W-1:0] syn;
    bits = cw;
    syn  = '0;
    for (int i = 0; i < `RF_CW_W; i++) begin
      if (bits[i]) begin
        syn ^= RF_ECC_COLS[i];
      end
    end
    return syn;
  endfunction

endpackage

//--- regfile/regfile_ff.sv
/*
 * Flip-flop register file of ECC codewords
 * One write port, two asynchronous read ports, entry zero reads as zero
 */

`timescale 1ns/10ps

`include "ibex_shell_cfg.svh"

module regfile_ff (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ibex_shell_pkg::rf_wr_t   wr_i,
  input  ibex_shell_pkg::rf_addr_t raddr_a_i,
  input  ibex_shell_pkg::rf_addr_t raddr_b_i,
  output ibex_shell_pkg::rf_cw_t   rdata_a_o,
  output ibex_shell_pkg::rf_cw_t   rdata_b_o
);

  import ibex_shell_pkg::*;

  logic [`RF_NUM_REGS-1:1] we_dec;
  rf_cw_t                  rf_q   [1:`RF_NUM_REGS-1];
  rf_cw_t                  rf_all [`RF_NUM_REGS];

  //////////////////////////////
  // Write port
  //////////////////////////////

  // One-hot enables, no enable exists for entry zero
  always_comb begin
    for (int i = 1; i < `RF_NUM_REGS; i++) begin
      we_dec[i] = wr_i.we && (wr_i.waddr == rf_addr_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `RF_NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `RF_NUM_REGS; i++) begin
        if (we_dec[i]) begin
          rf_q[i] <= wr_i.wdata;
        end
      end
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Zero codeword is all zeros, so it needs no check bits
  always_comb begin
    rf_all[0] = '0;
    for (int i = 1; i < `RF_NUM_REGS; i++) begin
      rf_all[i] = rf_q[i];
    end
  end

  assign rdata_a_o = rf_all[raddr_a_i];
  assign rdata_b_o = rf_all[raddr_b_i];

endmodule

//--- regfile/regfile_ecc_check.sv
/*
 * SEC-DED check for one register file read port
 * Corrects single-bit errors and flags double-bit errors
 */

`timescale 1ns/10ps

`include "ibex_shell_cfg.svh"

module regfile_ecc_check (
  input  ibex_shell_pkg::rf_cw_t cw_i,
  output ibex_shell_pkg::rf_rd_t rd_o
);

  import ibex_shell_pkg::*;

  logic [`RF_ECC_W-1:0] syndrome;
  logic                 col_hit;
  rf_data_t             data_fix;

  assign syndrome = rf_ecc_syndrome(cw_i);

  //////////////////////////////
  // Syndrome decode
  //////////////////////////////

  // Match against every column, check bit columns included
  always_comb begin
    col_hit = 1'b0;
    for (int i = 0; i < `RF_CW_W; i++) begin
      if (syndrome == RF_ECC_COLS[i]) begin
        col_hit = 1'b1;
      end
    end
  end

  // Only data columns flip a bit, a check bit error leaves data alone
  always_comb begin
    data_fix = cw_i.data;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      if (syndrome == RF_ECC_COLS[i]) begin
        data_fix[i] = ~cw_i.data[i];
      end
    end
  end

  // Uncorrectable case passes the raw data through
  always_comb begin
    rd_o.data       = data_fix;
    rd_o.err_single = col_hit;
    rd_o.err_double = (syndrome != '0) && !col_hit;
  end

endmodule

//--- verilog/sleep_ctrl.sv
/*
 * Main clock gate with sleep control
 * Sticky fetch enable, busy register, wake-up enable and latch clock gate
 */

`timescale 1ns/10ps

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic fetch_enable_i,
  input  logic core_busy_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic debug_req_i,
  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic fetch_enable_q;
  logic busy_q;
  logic clock_en;
  logic en_latch;

  // Set once, held until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  assign clock_en     = fetch_enable_q & (busy_q | debug_req_i | irq_pending_i | irq_nm_i);
  assign core_sleep_o = ~clock_en;

  // Transparent while clk_i is low, so the enable is stable over the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch = clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & en_latch;

endmodule

//--- verilog/ibex_shell_top.sv
/*
 * Core shell top level
 * Sleep controller, ECC register file, two read checkers and alert merge
 */

`timescale 1ns/10ps

module ibex_shell_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     test_en_i,
  input  logic                     fetch_enable_i,
  input  logic                     core_busy_i,
  input  logic                     irq_pending_i,
  input  logic                     irq_nm_i,
  input  logic                     debug_req_i,
  input  ibex_shell_pkg::rf_wr_t   rf_wr_i,
  input  ibex_shell_pkg::rf_addr_t rf_raddr_a_i,
  input  ibex_shell_pkg::rf_addr_t rf_raddr_b_i,
  output ibex_shell_pkg::rf_data_t rf_rdata_a_o,
  output ibex_shell_pkg::rf_data_t rf_rdata_b_o,
  output logic                     alert_minor_o,
  output logic                     alert_major_o,
  output logic                     core_sleep_o
);

  import ibex_shell_pkg::*;

  logic   clk_gated;
  rf_cw_t cw_a;
  rf_cw_t cw_b;
  rf_rd_t rd_a;
  rf_rd_t rd_b;

  sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_en_i      (test_en_i),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .irq_pending_i  (irq_pending_i),
    .irq_nm_i       (irq_nm_i),
    .debug_req_i    (debug_req_i),
    .clk_gated_o    (clk_gated),
    .core_sleep_o   (core_sleep_o)
  );

  // Register file only sees a clock while the core is awake
  regfile_ff u_regfile (
    .clk_i     (clk_gated),
    .rst_ni    (rst_ni),
    .wr_i      (rf_wr_i),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .rdata_a_o (cw_a),
    .rdata_b_o (cw_b)
  );

  regfile_ecc_check u_check_a (
    .cw_i (cw_a),
    .rd_o (rd_a)
  );

  regfile_ecc_check u_check_b (
    .cw_i (cw_b),
    .rd_o (rd_b)
  );

  //////////////////////////////
  // Outputs and alerts
  //////////////////////////////

  assign rf_rdata_a_o  = rd_a.data;
  assign rf_rdata_b_o  = rd_b.data;
  assign alert_minor_o = rd_a.err_single | rd_b.err_single;
  assign alert_major_o = rd_a.err_double | rd_b.err_double;

endmodule

//--- dv/ibex_shell_properties.sv
/*
 * Concurrent assertions on sleep and alert outputs, bound into the shell top
 */

`timescale 1ns/10ps

module ibex_shell_properties (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   fetch_enable_i,
  input logic                   core_sleep_i,
  input logic                   alert_minor_i,
  input logic                   alert_major_i,
  input ibex_shell_pkg::rf_rd_t rd_a_i,
  input ibex_shell_pkg::rf_rd_t rd_b_i
);

  logic fetch_seen_q;

  // Sticky copy of fetch enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  alerts_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({alert_minor_i, alert_major_i}))
    else $error("alert outputs unknown after reset");

  // One port never reports both error kinds
  port_flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (alert_minor_i && alert_major_i) |->
      ((rd_a_i.err_single && rd_b_i.err_double) ||
       (rd_a_i.err_double && rd_b_i.err_single)))
    else $error("a read port flags single and double error together");

  sleep_until_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_seen_q |-> core_sleep_i)
    else $error("core woke before fetch enable was seen");

endmodule

bind ibex_shell_top ibex_shell_properties u_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .fetch_enable_i (fetch_enable_i),
  .core_sleep_i   (core_sleep_o),
  .alert_minor_i  (alert_minor_o),
  .alert_major_i  (alert_major_o),
  .rd_a_i         (rd_a),
  .rd_b_i         (rd_b)
);

//--- dv/ibex_shell_tb.sv
/*
 * Directed testbench for the core shell
 * Sleep control, register file write and read, SEC-DED alert tests
 */

`timescale 1ns/10ps

`include "ibex_shell_cfg.svh"

module ibex_shell_tb;

  import ibex_shell_pkg::*;

  localparam int CLK_PERIOD_NS = 10;
  localparam int TEST_CYCLES   = 100;
  localparam int WATCHDOG_NS   = 20 * TEST_CYCLES * CLK_PERIOD_NS;

  logic     clk_i;
  logic     rst_ni;
  logic     test_en_i;
  logic     fetch_enable_i;
  logic     core_busy_i;
  logic     irq_pending_i;
  logic     irq_nm_i;
  logic     debug_req_i;
  rf_wr_t   rf_wr_i;
  rf_addr_t rf_raddr_a_i;
  rf_addr_t rf_raddr_b_i;
  rf_data_t rf_rdata_a_o;
  rf_data_t rf_rdata_b_o;
  logic     alert_minor_o;
  logic     alert_major_o;
  logic     core_sleep_o;

  int       seed;
  int       error_count;
  int       check_count;
  // Expected data word per register
  rf_data_t model [`RF_NUM_REGS];

  ibex_shell_top dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_en_i      (test_en_i),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .irq_pending_i  (irq_pending_i),
    .irq_nm_i       (irq_nm_i),
    .debug_req_i    (debug_req_i),
    .rf_wr_i        (rf_wr_i),
    .rf_raddr_a_i   (rf_raddr_a_i),
    .rf_raddr_b_i   (rf_raddr_b_i),
    .rf_rdata_a_o   (rf_rdata_a_o),
    .rf_rdata_b_o   (rf_rdata_b_o),
    .alert_minor_o  (alert_minor_o),
    .alert_major_o  (alert_major_o),
    .core_sleep_o   (core_sleep_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
    end
  end

  //////////////////////////////
  // Compare and drive helpers
  //////////////////////////////

  task automatic compare_data(input string test, input rf_data_t expected,
                              input rf_data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error [%s] read data: expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic compare_flag(input string test, input string signal,
                              input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error [%s] %s: expected %b, actual %b", test, signal, expected, actual);
    end
  endtask

  function automatic rf_cw_t encode_word(input rf_data_t data);
    rf_cw_t cw;
    cw.check = rf_ecc_encode(data);
    cw.data  = data;
    return cw;
  endfunction

  function automatic rf_addr_t pick_reg();
    return rf_addr_t'(1 + ($unsigned($random(seed)) % (`RF_NUM_REGS - 1)));
  endfunction

  // Strobe for one cycle, captured at the following edge
  task automatic write_reg(input rf_addr_t addr, input rf_cw_t cw);
    rf_wr_t wr;
    wr.we    = 1'b1;
    wr.waddr = addr;
    wr.wdata = cw;
    @(posedge clk_i);
    rf_wr_i <= wr;
    @(posedge clk_i);
    rf_wr_i.we <= 1'b0;
  endtask

  // Reads are combinational, outputs settle by the falling edge
  task automatic read_regs(input rf_addr_t addr_a, input rf_addr_t addr_b);
    @(posedge clk_i);
    rf_raddr_a_i <= addr_a;
    rf_raddr_b_i <= addr_b;
    @(negedge clk_i);
  endtask

  task automatic check_alerts(input string test, input logic minor, input logic major);
    compare_flag(test, "alert_minor_o", minor, alert_minor_o);
    compare_flag(test, "alert_major_o", major, alert_major_o);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_sleep_after_reset();
    string name = "sleep_after_reset";
    @(negedge clk_i);
    compare_flag(name, "core_sleep_o", 1'b1, core_sleep_o);
    check_alerts(name, 1'b0, 1'b0);
    @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    core_busy_i    <= 1'b1;
    @(negedge clk_i);
    compare_flag(name, "core_sleep_o", 1'b1, core_sleep_o);
    @(negedge clk_i);
    compare_flag(name, "core_sleep_o", 1'b0, core_sleep_o);
    @(posedge clk_i);
    fetch_enable_i <= 1'b0;
    repeat (3) @(negedge clk_i);
    compare_flag(name, "core_sleep_o", 1'b0, core_sleep_o);
  endtask

  task automatic test_write_read();
    string    name = "write_read";
    rf_addr_t addrs [8];
    rf_data_t data;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = pick_reg();
      data     = $random(seed);
      write_reg(addrs[i], encode_word(data));
      model[addrs[i]] = data;
    end
    for (int i = 0; i < 8; i++) begin
      read_regs(addrs[i], addrs[7 - i]);
      compare_data(name, model[addrs[i]], rf_rdata_a_o);
      compare_data(name, model[addrs[7 - i]], rf_rdata_b_o);
      check_alerts(name, 1'b0, 1'b0);
    end
    read_regs('0, '0);
    compare_data(name, '0, rf_rdata_a_o);
    compare_data(name, '0, rf_rdata_b_o);
  endtask

  task automatic test_sleep_write_lost();
    string    name = "sleep_write_lost";
    rf_addr_t addr;
    rf_data_t data;
    addr = pick_reg();
    data = $random(seed);
    @(posedge clk_i);
    core_busy_i   <= 1'b0;
    debug_req_i   <= 1'b0;
    irq_pending_i <= 1'b0;
    irq_nm_i      <= 1'b0;
    // Busy register needs one more edge
    repeat (2) @(negedge clk_i);
    compare_flag(name, "core_sleep_o", 1'b1, core_sleep_o);
    write_reg(addr, encode_word(data));
    read_regs(addr, addr);
    compare_data(name, model[addr], rf_rdata_a_o);
    compare_data(name, model[addr], rf_rdata_b_o);
    @(posedge clk_i);
    debug_req_i <= 1'b1;
    @(negedge clk_i);
    compare_flag(name, "core_sleep_o", 1'b0, core_sleep_o);
    write_reg(addr, encode_word(data));
    model[addr] = data;
    read_regs(addr, addr);
    compare_data(name, model[addr], rf_rdata_a_o);
    compare_data(name, model[addr], rf_rdata_b_o);
    check_alerts(name, 1'b0, 1'b0);
    // Hand the wake-up back to busy without a sleeping cycle
    @(posedge clk_i);
    core_busy_i <= 1'b1;
    @(posedge clk_i);
    debug_req_i <= 1'b0;
  endtask

  task automatic test_single_error();
    string               name = "single_error";
    rf_addr_t            addr;
    rf_data_t            data;
    rf_cw_t              cw;
    logic [`RF_CW_W-1:0] flip;
    int                  bit_pos;
    addr    = pick_reg();
    data    = $random(seed);
    bit_pos = $unsigned($random(seed)) % `RF_CW_W;
    flip    = '0;
    flip[bit_pos] = 1'b1;
    cw = encode_word(data) ^ flip;
    write_reg(addr, cw);
    model[addr] = data;
    read_regs(addr, '0);
    compare_data(name, data, rf_rdata_a_o);
    compare_data(name, '0, rf_rdata_b_o);
    check_alerts(name, 1'b1, 1'b0);
  endtask

  task automatic test_double_error();
    string               name = "double_error";
    rf_addr_t            addr;
    rf_data_t            data;
    rf_cw_t              cw;
    logic [`RF_CW_W-1:0] flip;
    int                  pos_a;
    int                  pos_b;
    addr  = pick_reg();
    data  = $random(seed);
    pos_a = $unsigned($random(seed)) % `RF_CW_W;
    // Offset of 1 to 38 keeps the second bit distinct
    pos_b = (pos_a + 1 + ($unsigned($random(seed)) % (`RF_CW_W - 1))) % `RF_CW_W;
    flip  = '0;
    flip[pos_a] = 1'b1;
    flip[pos_b] = 1'b1;
    cw = encode_word(data) ^ flip;
    write_reg(addr, cw);
    read_regs(addr, '0);
    // Uncorrectable, so the raw stored data comes out
    compare_data(name, cw.data, rf_rdata_a_o);
    compare_data(name, '0, rf_rdata_b_o);
    check_alerts(name, 1'b0, 1'b1);
  endtask

  //////////////////////////////
  // Sequence and report
  //////////////////////////////

  initial begin
    seed        = 32'heafd;
    error_count = 0;
    check_count = 0;
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      model[i] = '0;
    end
    rst_ni         <= 1'b0;
    test_en_i      <= 1'b0;
    fetch_enable_i <= 1'b0;
    core_busy_i    <= 1'b0;
    irq_pending_i  <= 1'b0;
    irq_nm_i       <= 1'b0;
    debug_req_i    <= 1'b0;
    rf_wr_i        <= '0;
    rf_raddr_a_i   <= '0;
    rf_raddr_b_i   <= '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_sleep_after_reset();
    test_write_read();
    test_sleep_write_lost();
    test_single_error();
    test_double_error();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- ibex_shell.f
+incdir+common
common/ibex_shell_pkg.sv
regfile/regfile_ff.sv
regfile/regfile_ecc_check.sv
verilog/sleep_ctrl.sv
verilog/ibex_shell_top.sv
dv/ibex_shell_properties.sv
dv/ibex_shell_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the shell testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f ibex_shell.f \
  --top-module ibex_shell_tb \
  -o ibex_shell_sim

./obj_dir/ibex_shell_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "FAIL: see $LOG"
  exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
  echo "FAIL: no pass report in $LOG"
  exit 1
fi

echo "PASS"
